// ==== rtl/wave_defines.svh ====
`ifndef WAVE_DEFINES_SVH
`define WAVE_DEFINES_SVH

// Half-period and step counter width
`define WAVE_CNT_W 16

// Signed triangle level width
`define WAVE_TRI_W 16

// Unsigned gain, 8 fraction bits, 256 is unity
`define WAVE_GAIN_W 16
`define WAVE_GAIN_FRAC 8

// Signed output sample width
`define WAVE_OUT_W 16

`define WAVE_FIFO_DEPTH 8

// AXI4-Lite address width, data is 32 bits
`define WAVE_AXI_AW 8

`endif

// ==== rtl/wave_pkg.sv ====
`include "wave_defines.svh"

package wave_pkg;

  // Word addresses of the register block
  typedef enum logic [`WAVE_AXI_AW-1:0] {
    CTRL   = 'h00,
    HALF   = 'h04,
    STEP   = 'h08,
    GAIN   = 'h0C,
    STATUS = 'h10
  } reg_addr_e;

  typedef enum logic {
    RELOAD,
    COUNTING
  } osc_state_e;

  typedef enum logic {
    UP,
    DOWN
  } osc_dir_e;

  // Control values from the register block
  typedef struct packed {
    logic                    enable;
    logic [`WAVE_CNT_W-1:0]  half;
    logic [`WAVE_CNT_W-1:0]  step;
    logic [`WAVE_GAIN_W-1:0] gain;
  } osc_cfg_t;

  // Oscillator level, valid pulses once per step
  typedef struct packed {
    logic                          valid;
    logic signed [`WAVE_TRI_W-1:0] level;
  } tri_sample_t;

  typedef struct packed {
    logic                          valid;
    logic signed [`WAVE_OUT_W-1:0] data;
  } out_sample_t;

endpackage

// ==== rtl/wave_regs.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "wave_defines.svh"

module wave_regs (
  input  logic                    clk,
  input  logic                    rst_n,

  input  logic [`WAVE_AXI_AW-1:0] s_axi_awaddr,
  input  logic                    s_axi_awvalid,
  output logic                    s_axi_awready,
  input  logic [31:0]             s_axi_wdata,
  input  logic [3:0]              s_axi_wstrb,
  input  logic                    s_axi_wvalid,
  output logic                    s_axi_wready,
  output logic [1:0]              s_axi_bresp,
  output logic                    s_axi_bvalid,
  input  logic                    s_axi_bready,
  input  logic [`WAVE_AXI_AW-1:0] s_axi_araddr,
  input  logic                    s_axi_arvalid,
  output logic                    s_axi_arready,
  output logic [31:0]             s_axi_rdata,
  output logic [1:0]              s_axi_rresp,
  output logic                    s_axi_rvalid,
  input  logic                    s_axi_rready,

  output wave_pkg::osc_cfg_t      cfg,
  input  logic                    overflow,
  input  logic [15:0]             sample_count,
  output logic                    clear_overflow
);

  wave_pkg::reg_addr_e wr_addr;
  wave_pkg::reg_addr_e rd_addr;
  logic                aw_start;
  logic                ar_start;
  logic                wr_en;
  logic                rd_en;
  logic [31:0]         wr_merged;
  logic [31:0]         rd_word;

  // Current value of a register word, unmapped reads as zero
  function automatic logic [31:0] reg_word(input wave_pkg::reg_addr_e addr,
                                           input wave_pkg::osc_cfg_t c,
                                           input logic ovf,
                                           input logic [15:0] cnt);
    case (addr)
      wave_pkg::CTRL:   return {31'b0, c.enable};
      wave_pkg::HALF:   return {{(32-`WAVE_CNT_W){1'b0}}, c.half};
      wave_pkg::STEP:   return {{(32-`WAVE_CNT_W){1'b0}}, c.step};
      wave_pkg::GAIN:   return {{(32-`WAVE_GAIN_W){1'b0}}, c.gain};
      wave_pkg::STATUS: return {cnt, 15'b0, ovf};
      default:          return 32'b0;
    endcase
  endfunction

  function automatic logic [31:0] apply_strb(input logic [31:0] old_val,
                                             input logic [31:0] new_val,
                                             input logic [3:0]  strb);
    logic [31:0] result;
    for (int i = 0; i < 4; i++) begin
      result[8*i +: 8] = strb[i] ? new_val[8*i +: 8] : old_val[8*i +: 8];
    end
    return result;
  endfunction

  // Word aligned decode
  assign wr_addr = wave_pkg::reg_addr_e'({s_axi_awaddr[`WAVE_AXI_AW-1:2], 2'b00});
  assign rd_addr = wave_pkg::reg_addr_e'({s_axi_araddr[`WAVE_AXI_AW-1:2], 2'b00});

  // One transaction in flight per direction
  assign aw_start = s_axi_awvalid && s_axi_wvalid && !s_axi_awready && !s_axi_bvalid;
  assign ar_start = s_axi_arvalid && !s_axi_arready && !s_axi_rvalid;
  assign wr_en    = s_axi_awready && s_axi_awvalid && s_axi_wvalid;
  assign rd_en    = s_axi_arready && s_axi_arvalid;

  assign wr_merged = apply_strb(reg_word(wr_addr, cfg, overflow, sample_count),
                                s_axi_wdata, s_axi_wstrb);
  assign rd_word   = reg_word(rd_addr, cfg, overflow, sample_count);

  // Always OKAY
  assign s_axi_bresp = 2'b00;
  assign s_axi_rresp = 2'b00;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s_axi_awready  <= 1'b0;
      s_axi_wready   <= 1'b0;
      s_axi_bvalid   <= 1'b0;
      s_axi_arready  <= 1'b0;
      s_axi_rvalid   <= 1'b0;
      cfg            <= '0;
      clear_overflow <= 1'b0;
    end else begin
      s_axi_awready  <= aw_start;
      s_axi_wready   <= aw_start;
      s_axi_arready  <= ar_start;
      clear_overflow <= 1'b0;

      if (wr_en) begin
        s_axi_bvalid <= 1'b1;
      end else if (s_axi_bready) begin
        s_axi_bvalid <= 1'b0;
      end

      if (rd_en) begin
        s_axi_rvalid <= 1'b1;
      end else if (s_axi_rready) begin
        s_axi_rvalid <= 1'b0;
      end

      if (wr_en) begin
        case (wr_addr)
          wave_pkg::CTRL:   cfg.enable <= wr_merged[0];
          wave_pkg::HALF:   cfg.half   <= wr_merged[`WAVE_CNT_W-1:0];
          wave_pkg::STEP:   cfg.step   <= wr_merged[`WAVE_CNT_W-1:0];
          wave_pkg::GAIN:   cfg.gain   <= wr_merged[`WAVE_GAIN_W-1:0];
          // Write one to clear
          wave_pkg::STATUS: clear_overflow <= s_axi_wstrb[0] && s_axi_wdata[0];
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_en) begin
      s_axi_rdata <= rd_word;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/osc_triangle.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "wave_defines.svh"

module osc_triangle (
  input  logic                  clk,
  input  logic                  rst_n,
  input  wave_pkg::osc_cfg_t    cfg,
  output wave_pkg::tri_sample_t tri_out
);

  localparam logic signed [`WAVE_TRI_W-1:0] level_low = {1'b1, {(`WAVE_TRI_W-1){1'b0}}};

  wave_pkg::osc_state_e          state;
  wave_pkg::osc_dir_e            dir;
  logic [`WAVE_CNT_W-1:0]        half_q;
  logic [`WAVE_CNT_W-1:0]        step_q;
  logic [`WAVE_CNT_W-1:0]        half_cnt;
  logic [`WAVE_CNT_W-1:0]        step_cnt;
  logic signed [`WAVE_TRI_W-1:0] level;
  logic                          valid_q;
  logic                          half_done;
  logic                          step_hit;

  assign half_done = (half_cnt == half_q - `WAVE_CNT_W'(1));
  assign step_hit  = (step_cnt == step_q);

  assign tri_out = '{valid: valid_q, level: level};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= wave_pkg::RELOAD;
      dir      <= wave_pkg::UP;
      half_q   <= '0;
      step_q   <= '0;
      half_cnt <= '0;
      step_cnt <= '0;
      level    <= '0;
      valid_q  <= 1'b0;
    end else begin
      valid_q <= 1'b0;

      case (state)
        wave_pkg::RELOAD: begin
          // Half and step only change at the start of a period
          if (cfg.enable) begin
            half_q   <= cfg.half;
            step_q   <= cfg.step;
            level    <= level_low;
            half_cnt <= '0;
            step_cnt <= '0;
            dir      <= wave_pkg::UP;
            state    <= wave_pkg::COUNTING;
          end
        end

        wave_pkg::COUNTING: begin
          if (!cfg.enable) begin
            state <= wave_pkg::RELOAD;
          end else begin
            half_cnt <= half_cnt + `WAVE_CNT_W'(1);
            step_cnt <= step_cnt + `WAVE_CNT_W'(1);

            if (step_hit) begin
              step_cnt <= '0;
              valid_q  <= 1'b1;
              if (dir == wave_pkg::UP) begin
                level <= level + `WAVE_TRI_W'(1);
              end else begin
                level <= level - `WAVE_TRI_W'(1);
              end
            end

            // End of a half period
            if (half_done) begin
              half_cnt <= '0;
              step_cnt <= '0;
              if (dir == wave_pkg::UP) begin
                dir <= wave_pkg::DOWN;
              end else begin
                state <= wave_pkg::RELOAD;
              end
            end
          end
        end

        default: state <= wave_pkg::RELOAD;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== rtl/osc_gain.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "wave_defines.svh"

module osc_gain (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic [`WAVE_GAIN_W-1:0] gain,
  input  wave_pkg::tri_sample_t   tri_in,
  output wave_pkg::out_sample_t   smp_out
);

  localparam int prod_w = `WAVE_TRI_W + `WAVE_GAIN_W + 1;

  localparam logic signed [prod_w-1:0] sat_max =
    {{(prod_w-`WAVE_OUT_W+1){1'b0}}, {(`WAVE_OUT_W-1){1'b1}}};
  localparam logic signed [prod_w-1:0] sat_min =
    {{(prod_w-`WAVE_OUT_W+1){1'b1}}, {(`WAVE_OUT_W-1){1'b0}}};

  logic signed [prod_w-1:0]      product;
  logic signed [prod_w-1:0]      scaled;
  logic signed [`WAVE_OUT_W-1:0] sat;
  logic signed [`WAVE_OUT_W-1:0] data_q;
  logic                          valid_q;

  // Gain is unsigned, zero extend before the signed multiply
  assign product = $signed(tri_in.level) * $signed({1'b0, gain});
  assign scaled  = product >>> `WAVE_GAIN_FRAC;

  always_comb begin
    if (scaled > sat_max) begin
      sat = sat_max[`WAVE_OUT_W-1:0];
    end else if (scaled < sat_min) begin
      sat = sat_min[`WAVE_OUT_W-1:0];
    end else begin
      sat = scaled[`WAVE_OUT_W-1:0];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= tri_in.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (tri_in.valid) begin
      data_q <= sat;
    end
  end

  assign smp_out = '{valid: valid_q, data: data_q};

endmodule

`default_nettype wire

// ==== rtl/sample_fifo.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "wave_defines.svh"

module sample_fifo (
  input  logic                          clk,
  input  logic                          rst_n,
  input  wave_pkg::out_sample_t         smp_in,
  output logic                          out_valid,
  output logic signed [`WAVE_OUT_W-1:0] out_data,
  input  logic                          out_ready,
  input  logic                          clear_overflow,
  output logic                          overflow,
  output logic [15:0]                   sample_count
);

  localparam int ptr_w = $clog2(`WAVE_FIFO_DEPTH);
  localparam int cnt_w = $clog2(`WAVE_FIFO_DEPTH + 1);

  logic signed [`WAVE_OUT_W-1:0] mem [`WAVE_FIFO_DEPTH];
  logic [ptr_w-1:0]              wr_ptr;
  logic [ptr_w-1:0]              rd_ptr;
  logic [cnt_w-1:0]              fill;
  logic                          full;
  logic                          push;
  logic                          pop;
  logic                          drop;

  function automatic logic [ptr_w-1:0] ptr_next(input logic [ptr_w-1:0] p);
    return (p == ptr_w'(`WAVE_FIFO_DEPTH - 1)) ? '0 : p + ptr_w'(1);
  endfunction

  assign full      = (fill == cnt_w'(`WAVE_FIFO_DEPTH));
  assign out_valid = (fill != '0);
  // Head entry is a register, no path from the input
  assign out_data  = mem[rd_ptr];

  assign pop  = out_valid && out_ready;
  assign push = smp_in.valid && (!full || pop);
  assign drop = smp_in.valid && full && !pop;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr       <= '0;
      rd_ptr       <= '0;
      fill         <= '0;
      overflow     <= 1'b0;
      sample_count <= '0;
    end else begin
      if (push) begin
        wr_ptr       <= ptr_next(wr_ptr);
        sample_count <= sample_count + 16'd1;
      end
      if (pop) begin
        rd_ptr <= ptr_next(rd_ptr);
      end
      if (push && !pop) begin
        fill <= fill + cnt_w'(1);
      end else if (pop && !push) begin
        fill <= fill - cnt_w'(1);
      end

      // A new drop wins over a clear in the same cycle
      if (drop) begin
        overflow <= 1'b1;
      end else if (clear_overflow) begin
        overflow <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= smp_in.data;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/wave_gen_top.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "wave_defines.svh"

module wave_gen_top (
  input  logic                          clk,
  input  logic                          rst_n,

  input  logic [`WAVE_AXI_AW-1:0]       s_axi_awaddr,
  input  logic                          s_axi_awvalid,
  output logic                          s_axi_awready,
  input  logic [31:0]                   s_axi_wdata,
  input  logic [3:0]                    s_axi_wstrb,
  input  logic                          s_axi_wvalid,
  output logic                          s_axi_wready,
  output logic [1:0]                    s_axi_bresp,
  output logic                          s_axi_bvalid,
  input  logic                          s_axi_bready,
  input  logic [`WAVE_AXI_AW-1:0]       s_axi_araddr,
  input  logic                          s_axi_arvalid,
  output logic                          s_axi_arready,
  output logic [31:0]                   s_axi_rdata,
  output logic [1:0]                    s_axi_rresp,
  output logic                          s_axi_rvalid,
  input  logic                          s_axi_rready,

  output logic                          out_valid,
  output logic signed [`WAVE_OUT_W-1:0] out_data,
  input  logic                          out_ready
);

  wave_pkg::osc_cfg_t    cfg;
  wave_pkg::tri_sample_t tri_sample;
  wave_pkg::out_sample_t gain_sample;
  logic                  overflow;
  logic [15:0]           sample_count;
  logic                  clear_overflow;

  wave_regs i_wave_regs (
    .clk            (clk),
    .rst_n          (rst_n),
    .s_axi_awaddr   (s_axi_awaddr),
    .s_axi_awvalid  (s_axi_awvalid),
    .s_axi_awready  (s_axi_awready),
    .s_axi_wdata    (s_axi_wdata),
    .s_axi_wstrb    (s_axi_wstrb),
    .s_axi_wvalid   (s_axi_wvalid),
    .s_axi_wready   (s_axi_wready),
    .s_axi_bresp    (s_axi_bresp),
    .s_axi_bvalid   (s_axi_bvalid),
    .s_axi_bready   (s_axi_bready),
    .s_axi_araddr   (s_axi_araddr),
    .s_axi_arvalid  (s_axi_arvalid),
    .s_axi_arready  (s_axi_arready),
    .s_axi_rdata    (s_axi_rdata),
    .s_axi_rresp    (s_axi_rresp),
    .s_axi_rvalid   (s_axi_rvalid),
    .s_axi_rready   (s_axi_rready),
    .cfg            (cfg),
    .overflow       (overflow),
    .sample_count   (sample_count),
    .clear_overflow (clear_overflow)
  );

  osc_triangle i_osc_triangle (
    .clk     (clk),
    .rst_n   (rst_n),
    .cfg     (cfg),
    .tri_out (tri_sample)
  );

  osc_gain i_osc_gain (
    .clk     (clk),
    .rst_n   (rst_n),
    .gain    (cfg.gain),
    .tri_in  (tri_sample),
    .smp_out (gain_sample)
  );

  sample_fifo i_sample_fifo (
    .clk            (clk),
    .rst_n          (rst_n),
    .smp_in         (gain_sample),
    .out_valid      (out_valid),
    .out_data       (out_data),
    .out_ready      (out_ready),
    .clear_overflow (clear_overflow),
    .overflow       (overflow),
    .sample_count   (sample_count)
  );

endmodule

`default_nettype wire

// ==== bench/wave_gen_assert.sv ====
`timescale 1ns/100ps
`include "wave_defines.svh"

module wave_gen_assert (
  input logic                   clk,
  input logic                   rst_n,
  input logic                   s_axi_bvalid,
  input logic                   s_axi_bready,
  input logic                   s_axi_rvalid,
  input logic                   s_axi_rready,
  input logic                   out_valid,
  input logic                   out_ready,
  input logic [`WAVE_OUT_W-1:0] out_data,
  input logic                   overflow,
  input logic                   clear_overflow
);

  int fail_count = 0;

  bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
    s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid)
    else begin
      $error("bvalid dropped before bready");
      fail_count++;
    end

  rvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
    s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid)
    else begin
      $error("rvalid dropped before rready");
      fail_count++;
    end

  // Stalled head word must not change
  out_stable: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid && !out_ready |=> out_valid && $stable(out_data))
    else begin
      $error("out_data changed while stalled");
      fail_count++;
    end

  // Sticky flag
  overflow_sticky: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(overflow) |-> $past(clear_overflow))
    else begin
      $error("overflow fell without clear_overflow");
      fail_count++;
    end

endmodule

bind wave_gen_top wave_gen_assert i_wave_gen_assert (
  .clk            (clk),
  .rst_n          (rst_n),
  .s_axi_bvalid   (s_axi_bvalid),
  .s_axi_bready   (s_axi_bready),
  .s_axi_rvalid   (s_axi_rvalid),
  .s_axi_rready   (s_axi_rready),
  .out_valid      (out_valid),
  .out_ready      (out_ready),
  .out_data       (out_data),
  .overflow       (overflow),
  .clear_overflow (clear_overflow)
);

// ==== bench/wave_gen_tb.sv ====
`timescale 1ns/100ps
`include "wave_defines.svh"

module wave_gen_tb;

  localparam int clk_half_ns = 20;
  // Starting config of the reconfiguration test, and the top of its random half range
  localparam int reconf_half   = 64;
  localparam int reconf_step   = 3;
  localparam int rand_half_max = 47;
  localparam int period_sum    = 8 * (2 * 16 + 1) + 2 * (2 * reconf_half + 1)
                                 + 4 * (2 * rand_half_max + 1);
  localparam longint watchdog_ns = longint'(period_sum) * 4 * 2 * clk_half_ns + 10000;

  logic                          clk;
  logic                          rst_n;
  logic [`WAVE_AXI_AW-1:0]       s_axi_awaddr;
  logic                          s_axi_awvalid;
  logic                          s_axi_awready;
  logic [31:0]                   s_axi_wdata;
  logic [3:0]                    s_axi_wstrb;
  logic                          s_axi_wvalid;
  logic                          s_axi_wready;
  logic [1:0]                    s_axi_bresp;
  logic                          s_axi_bvalid;
  logic                          s_axi_bready;
  logic [`WAVE_AXI_AW-1:0]       s_axi_araddr;
  logic                          s_axi_arvalid;
  logic                          s_axi_arready;
  logic [31:0]                   s_axi_rdata;
  logic [1:0]                    s_axi_rresp;
  logic                          s_axi_rvalid;
  logic                          s_axi_rready;
  logic                          out_valid;
  logic signed [`WAVE_OUT_W-1:0] out_data;
  logic                          out_ready;

  int                            errors;
  int                            rx_total;
  logic signed [`WAVE_TRI_W-1:0] exp_levels[$];

  wave_gen_top i_wave_gen_top (.*);

  always #(clk_half_ns) clk = ~clk;

  initial begin
    #(watchdog_ns);
    $display("Timeout: the tests did not finish in the expected time");
    $display("Simulation finished: FAIL");
    $finish;
  end

  task automatic check_reg(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      errors++;
      $display("[FAIL] %s expected 0x%08h got 0x%08h", name, exp, act);
    end
  endtask

  task automatic check_sample(input wave_pkg::out_sample_t exp, input wave_pkg::out_sample_t act);
    if (act !== exp) begin
      errors++;
      $display("[FAIL] out_data expected 0x%04h got 0x%04h", exp.data, act.data);
    end
  endtask

  task automatic axi_write(input logic [`WAVE_AXI_AW-1:0] addr, input logic [31:0] data);
    @(posedge clk);
    s_axi_awaddr  <= addr;
    s_axi_awvalid <= 1'b1;
    s_axi_wdata   <= data;
    s_axi_wstrb   <= 4'hf;
    s_axi_wvalid  <= 1'b1;
    s_axi_bready  <= 1'b1;
    do @(posedge clk); while (!s_axi_awready);
    // wready rises together with awready
    check_reg("s_axi_wready", 32'd1, {31'b0, s_axi_wready});
    s_axi_awvalid <= 1'b0;
    s_axi_wvalid  <= 1'b0;
    do @(posedge clk); while (!s_axi_bvalid);
    check_reg("s_axi_bresp", 32'd0, {30'b0, s_axi_bresp});
    s_axi_bready  <= 1'b0;
  endtask

  task automatic axi_read(input logic [`WAVE_AXI_AW-1:0] addr, output logic [31:0] data);
    @(posedge clk);
    s_axi_araddr  <= addr;
    s_axi_arvalid <= 1'b1;
    s_axi_rready  <= 1'b1;
    do @(posedge clk); while (!s_axi_arready);
    s_axi_arvalid <= 1'b0;
    do @(posedge clk); while (!s_axi_rvalid);
    data = s_axi_rdata;
    check_reg("s_axi_rresp", 32'd0, {30'b0, s_axi_rresp});
    s_axi_rready  <= 1'b0;
  endtask

  task automatic read_check(input logic [`WAVE_AXI_AW-1:0] addr, input logic [31:0] exp,
                            input string name);
    logic [31:0] rd;
    axi_read(addr, rd);
    check_reg(name, exp, rd);
  endtask

  // Unsigned gain with 8 fraction bits, floor shift, clamp to the output range
  function automatic logic signed [`WAVE_OUT_W-1:0] scale_level(
      input logic signed [`WAVE_TRI_W-1:0] level, input int gain);
    longint prod;
    longint lim_hi;
    longint lim_lo;
    lim_hi = (64'sd1 <<< (`WAVE_OUT_W - 1)) - 64'sd1;
    lim_lo = -(64'sd1 <<< (`WAVE_OUT_W - 1));
    prod = (longint'(level) * longint'(gain)) >>> `WAVE_GAIN_FRAC;
    if (prod > lim_hi) begin
      prod = lim_hi;
    end else if (prod < lim_lo) begin
      prod = lim_lo;
    end
    return prod[`WAVE_OUT_W-1:0];
  endfunction

  // k steps up from the lowest level, then k steps back down
  task automatic build_levels(input int half, input int step, input int periods);
    logic signed [`WAVE_TRI_W-1:0] low;
    int k;
    low = {1'b1, {(`WAVE_TRI_W-1){1'b0}}};
    k = half / (step + 1);
    for (int p = 0; p < periods; p++) begin
      for (int i = 1; i <= k; i++) begin
        exp_levels.push_back(low + `WAVE_TRI_W'(i));
      end
      for (int i = k - 1; i >= 0; i--) begin
        exp_levels.push_back(low + `WAVE_TRI_W'(i));
      end
    end
  endtask

  task automatic collect_samples(input int n, input int gain);
    wave_pkg::out_sample_t exp;
    wave_pkg::out_sample_t act;
    int got;
    got = 0;
    while (got < n) begin
      @(posedge clk);
      if (out_valid && out_ready) begin
        act = '{valid: 1'b1, data: out_data};
        exp = '{valid: 1'b1, data: scale_level(exp_levels.pop_front(), gain)};
        check_sample(exp, act);
        got++;
        rx_total++;
      end
    end
  endtask

  // Accept whatever is left until the output has been quiet for a while
  task automatic drain_output();
    int idle;
    idle = 0;
    out_ready <= 1'b1;
    while (idle < 8) begin
      @(posedge clk);
      if (out_valid) begin
        idle = 0;
      end else begin
        idle++;
      end
    end
    out_ready <= 1'b0;
  endtask

  task automatic run_periods(input int half, input int step, input int gain, input int periods);
    exp_levels.delete();
    axi_write(wave_pkg::HALF, half);
    axi_write(wave_pkg::STEP, step);
    axi_write(wave_pkg::GAIN, gain);
    build_levels(half, step, periods);
    out_ready <= 1'b1;
    axi_write(wave_pkg::CTRL, 32'd1);
    collect_samples(exp_levels.size(), gain);
    axi_write(wave_pkg::CTRL, 32'd0);
    drain_output();
  endtask

  task automatic test_registers();
    read_check(wave_pkg::CTRL, 32'd0, "CTRL");
    read_check(wave_pkg::HALF, 32'd0, "HALF");
    read_check(wave_pkg::STEP, 32'd0, "STEP");
    read_check(wave_pkg::GAIN, 32'd0, "GAIN");
    read_check(wave_pkg::STATUS, 32'd0, "STATUS");
    axi_write(wave_pkg::HALF, 32'h0000_1234);
    axi_write(wave_pkg::STEP, 32'h0000_0056);
    axi_write(wave_pkg::GAIN, 32'h0000_0180);
    read_check(wave_pkg::HALF, 32'h0000_1234, "HALF");
    read_check(wave_pkg::STEP, 32'h0000_0056, "STEP");
    read_check(wave_pkg::GAIN, 32'h0000_0180, "GAIN");
    axi_write(wave_pkg::CTRL, 32'd1);
    read_check(wave_pkg::CTRL, 32'd1, "CTRL");
    axi_write(wave_pkg::CTRL, 32'd0);
    read_check(8'h14, 32'd0, "unmapped 0x14");
    read_check(8'hfc, 32'd0, "unmapped 0xfc");
    drain_output();
  endtask

  task automatic test_backpressure();
    logic [31:0] status;
    logic [15:0] count0;
    exp_levels.delete();
    axi_write(wave_pkg::HALF, 32'd16);
    axi_write(wave_pkg::STEP, 32'd3);
    axi_write(wave_pkg::GAIN, 32'd256);
    axi_read(wave_pkg::STATUS, status);
    count0 = status[31:16];
    build_levels(16, 3, 2);
    out_ready <= 1'b0;
    axi_write(wave_pkg::CTRL, 32'd1);
    do axi_read(wave_pkg::STATUS, status); while (!status[0]);
    axi_write(wave_pkg::CTRL, 32'd0);
    read_check(wave_pkg::STATUS, {count0 + 16'(`WAVE_FIFO_DEPTH), 15'b0, 1'b1}, "STATUS");
    out_ready <= 1'b1;
    collect_samples(`WAVE_FIFO_DEPTH, 256);
    drain_output();
    axi_write(wave_pkg::STATUS, 32'd1);
    read_check(wave_pkg::STATUS, {count0 + 16'(`WAVE_FIFO_DEPTH), 15'b0, 1'b0}, "STATUS");
  endtask

  task automatic test_reconfig();
    int new_half;
    int new_step;
    int new_gain;
    int n_old;
    int n_total;
    int rx_base;
    int bad;
    new_step = $urandom % 8;
    new_half = 16 + $urandom % (rand_half_max - 15);
    new_gain = 64 + $urandom % 448;
    exp_levels.delete();
    axi_write(wave_pkg::HALF, reconf_half);
    axi_write(wave_pkg::STEP, reconf_step);
    axi_write(wave_pkg::GAIN, new_gain);
    // Two periods on the old values, the writes land in the second one
    build_levels(reconf_half, reconf_step, 2);
    build_levels(new_half, new_step, 2);
    n_old   = 4 * (reconf_half / (reconf_step + 1));
    n_total = n_old + 4 * (new_half / (new_step + 1));
    rx_base = rx_total;
    out_ready <= 1'b1;
    axi_write(wave_pkg::CTRL, 32'd1);
    fork
      collect_samples(n_total, new_gain);
      begin
        wait (rx_total - rx_base > n_old / 2);
        axi_write(wave_pkg::STEP, new_step);
        axi_write(wave_pkg::HALF, new_half);
      end
    join
    axi_write(wave_pkg::CTRL, 32'd0);
    drain_output();
    bad = 0;
    out_ready <= 1'b1;
    repeat (2 * (2 * new_half + 1)) begin
      @(posedge clk);
      if (out_valid) begin
        bad++;
      end
    end
    out_ready <= 1'b0;
    if (bad != 0) begin
      errors++;
      $display("Samples appeared on the output while the generator was disabled");
    end
  endtask

  initial begin
    void'($urandom(11037));
    clk           = 1'b0;
    rst_n         = 1'b0;
    s_axi_awaddr  = '0;
    s_axi_awvalid = 1'b0;
    s_axi_wdata   = '0;
    s_axi_wstrb   = '0;
    s_axi_wvalid  = 1'b0;
    s_axi_bready  = 1'b0;
    s_axi_araddr  = '0;
    s_axi_arvalid = 1'b0;
    s_axi_rready  = 1'b0;
    out_ready     = 1'b0;
    errors        = 0;
    rx_total      = 0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;

    test_registers();
    run_periods(16, 3, 256, 2);
    run_periods(16, 3, 128, 1);
    run_periods(16, 3, 1024, 1);
    test_backpressure();
    test_reconfig();

    errors += i_wave_gen_top.i_wave_gen_assert.fail_count;
    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// ==== list.f ====
+incdir+rtl
rtl/wave_pkg.sv
rtl/wave_regs.sv
rtl/osc_triangle.sv
rtl/osc_gain.sv
rtl/sample_fifo.sv
rtl/wave_gen_top.sv
bench/wave_gen_assert.sv
bench/wave_gen_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= wave_gen_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing --assert
PASS_MSG  ?= Simulation finished: PASS

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# The run output is kept in a shell variable and searched for the pass line
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
